// File: verilog/exe_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types and constants of the execution unit front
// instruction word: opcode 31..24, r1 23..16, r2 15..8, r3 7..0
// opcodes not listed in vopcode_t execute as NO_OP
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package exe_pkg;

   // instruction buffer depth, per channel
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

   // scalar register file size
   localparam int SCALAR_REGS = 16;

   // one instruction or immediate word
   typedef logic [31:0] instr_word_t;

   // one 8-bit register field of an instruction
   typedef logic [7:0] instr_field_t;

   // scalar register value and index
   typedef logic [31:0] scalar_t;
   typedef logic [3:0] sreg_idx_t;

   // vector register index, low bits of r1
   typedef logic [4:0] vreg_idx_t;

   // vector length register
   typedef logic [31:0] vec_len_t;

   // reduced instruction set
   typedef enum logic [7:0] {
      NO_OP   = 8'h00,
      LV      = 8'h10,
      SV      = 8'h11,
      MTC1    = 8'h20,
      MFC1    = 8'h21,
      MOV_IMM = 8'h30
   } vopcode_t;

   // decoder waits for the data word of a MOV_IMM in DEC_IMM
   typedef enum logic {
      DEC_INSTR = 1'b0,
      DEC_IMM   = 1'b1
   } decode_state_t;

endpackage

// File: verilog/exe_issue_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one decoded instruction, decoder to executor
// transfer on a rising edge with valid and ready high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface exe_issue_if import exe_pkg::*; ();

   logic         valid;
   vopcode_t     op;
   instr_field_t r1;
   instr_field_t r2;
   instr_word_t  imm;
   logic         ready;

   modport decoder (output valid, op, r1, r2, imm, input ready);

   modport executor (input valid, op, r1, r2, imm, output ready);

endinterface

// File: verilog/opcode_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// circular instruction buffer, FIFO_DEPTH words
// source must not push while full is high
// pop on an empty buffer is ignored
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module opcode_fifo import exe_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        push,
   input  instr_word_t push_data,
   input  logic        pop,
   output instr_word_t head,
   output logic        empty,
   output logic        full
);

   instr_word_t mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_PTR_W:0]   count;
   logic do_push;
   logic do_pop;

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   assign head  = mem[rd_ptr];
   assign empty = (count == '0);
   assign full  = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // pointers wrap naturally, depth is a power of two
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // the source sees full through inst_buff_full at the top
   push_when_full: assert property (@(posedge clk) disable iff (!reset)
      push |-> !full)
      else $error("opcode_fifo: push while full");

endmodule

// File: verilog/instr_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// alternates strictly between the two buffers, channel 0 first
// MOV_IMM is held back until its data word is popped
// one decoded instruction register, refillable while handing over
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module instr_decode import exe_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  instr_word_t head0,
   input  logic        empty0,
   input  instr_word_t head1,
   input  logic        empty1,
   output logic        pop0,
   output logic        pop1,
   exe_issue_if.decoder issue
);

   decode_state_t state;
   logic        rr_ptr;
   instr_word_t sel_word;
   logic        sel_empty;
   logic        reg_free;
   logic        pop;
   vopcode_t    sel_op;

   // only the pointed buffer is looked at
   assign sel_word  = rr_ptr ? head1 : head0;
   assign sel_empty = rr_ptr ? empty1 : empty0;
   assign sel_op    = vopcode_t'(sel_word[31:24]);

   // register is free, or its instruction leaves this cycle
   assign reg_free = !issue.valid || issue.ready;
   assign pop      = !sel_empty && reg_free;
   assign pop0     = pop && !rr_ptr;
   assign pop1     = pop && rr_ptr;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state       <= DEC_INSTR;
         rr_ptr      <= 1'b0;
         issue.valid <= 1'b0;
      end else begin
         if (issue.valid && issue.ready) begin
            issue.valid <= 1'b0;
         end
         if (pop) begin
            rr_ptr <= ~rr_ptr;
            if (state == DEC_INSTR) begin
               if (sel_op == MOV_IMM) begin
                  // fields kept, valid waits for the data word
                  state       <= DEC_IMM;
                  issue.valid <= 1'b0;
               end else begin
                  issue.valid <= 1'b1;
               end
            end else begin
               state       <= DEC_INSTR;
               issue.valid <= 1'b1;
            end
         end
      end
   end

   // instruction payload
   always_ff @(posedge clk) begin
      if (pop) begin
         if (state == DEC_INSTR) begin
            issue.op <= sel_op;
            issue.r1 <= sel_word[23:16];
            issue.r2 <= sel_word[15:8];
         end else begin
            issue.imm <= sel_word;
         end
      end
   end

endmodule

// File: verilog/scalar_regfile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scalar registers, all cleared on reset
// combinational read, write at the rising edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module scalar_regfile import exe_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  sreg_idx_t rd_idx,
   output scalar_t   rd_data,
   input  logic      wr_en,
   input  sreg_idx_t wr_idx,
   input  scalar_t   wr_data
);

   scalar_t regs [SCALAR_REGS];

   // no bypass, a write is seen from the next cycle
   assign rd_data = regs[rd_idx];

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         for (int i = 0; i < SCALAR_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_idx] <= wr_data;
      end
   end

endmodule

// File: verilog/exe_control.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// executes decoded instructions, holds the vector length
// LV/SV request rises one cycle after transfer, held until accepted
// no new instruction is taken while a request is pending
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module exe_control import exe_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   exe_issue_if.executor issue,
   output sreg_idx_t rd_idx,
   input  scalar_t   rd_data,
   output logic      wr_en,
   output sreg_idx_t wr_idx,
   output scalar_t   wr_data,
   input  logic      ls_busy,
   output logic      ls_req_valid,
   output logic      ls_req_write,
   output vreg_idx_t ls_req_vreg,
   output scalar_t   ls_req_addr,
   output vec_len_t  ls_req_length
);

   vec_len_t vec_len;
   logic     fire;
   logic     is_mem;

   assign issue.ready = !ls_req_valid;
   assign fire        = issue.valid && issue.ready;
   assign is_mem      = (issue.op == LV) || (issue.op == SV);

   // r2 addresses the scalar source for MTC1, LV and SV
   assign rd_idx = issue.r2[$bits(sreg_idx_t)-1:0];
   assign wr_idx = issue.r1[$bits(sreg_idx_t)-1:0];

   // scalar writeback for MFC1 and MOV_IMM
   always_comb begin
      wr_en   = 1'b0;
      wr_data = issue.imm;
      case (issue.op)
         MFC1: begin
            wr_en   = fire;
            wr_data = vec_len;
         end
         MOV_IMM: begin
            wr_en = fire;
         end
         default: begin
            wr_en = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         vec_len      <= '0;
         ls_req_valid <= 1'b0;
      end else begin
         if (fire && (issue.op == MTC1)) begin
            vec_len <= rd_data;
         end
         if (fire && is_mem) begin
            ls_req_valid <= 1'b1;
         end else if (ls_req_valid && !ls_busy) begin
            ls_req_valid <= 1'b0;
         end
      end
   end

   // request fields, length sampled at transfer
   always_ff @(posedge clk) begin
      if (fire && is_mem) begin
         ls_req_write  <= (issue.op == SV);
         ls_req_vreg   <= issue.r1[$bits(vreg_idx_t)-1:0];
         ls_req_addr   <= rd_data;
         ls_req_length <= vec_len;
      end
   end

   // load/store unit relies on a steady request while it is busy
   req_stable: assert property (@(posedge clk) disable iff (!reset)
      ls_req_valid && ls_busy |=> ls_req_valid && $stable(ls_req_write)
         && $stable(ls_req_vreg) && $stable(ls_req_addr) && $stable(ls_req_length))
      else $error("exe_control: request changed while load/store busy");

endmodule

// File: verilog/vector_exe_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execution unit front, two instruction channels
// a push writes both channels, program order is opcode0 then opcode1
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vector_exe_unit import exe_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        opcode_vld,
   input  instr_word_t opcode0,
   input  instr_word_t opcode1,
   input  logic        ls_busy,
   output logic        inst_buff_full,
   output logic        ls_req_valid,
   output logic        ls_req_write,
   output vreg_idx_t   ls_req_vreg,
   output scalar_t     ls_req_addr,
   output vec_len_t    ls_req_length
);

   instr_word_t head0;
   instr_word_t head1;
   logic        empty0;
   logic        empty1;
   logic        full0;
   logic        full1;
   logic        pop0;
   logic        pop1;
   sreg_idx_t   rd_idx;
   scalar_t     rd_data;
   logic        wr_en;
   sreg_idx_t   wr_idx;
   scalar_t     wr_data;

   exe_issue_if issue_bus ();

   assign inst_buff_full = full0 || full1;

   opcode_fifo buffer0 (.clk(clk), .reset(reset), .push(opcode_vld), .push_data(opcode0),
      .pop(pop0), .head(head0), .empty(empty0), .full(full0));

   opcode_fifo buffer1 (.clk(clk), .reset(reset), .push(opcode_vld), .push_data(opcode1),
      .pop(pop1), .head(head1), .empty(empty1), .full(full1));

   instr_decode decoder (.clk(clk), .reset(reset), .head0(head0), .empty0(empty0),
      .head1(head1), .empty1(empty1), .pop0(pop0), .pop1(pop1), .issue(issue_bus.decoder));

   scalar_regfile sregs (.clk(clk), .reset(reset), .rd_idx(rd_idx), .rd_data(rd_data),
      .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data));

   exe_control executor (.clk(clk), .reset(reset), .issue(issue_bus.executor),
      .rd_idx(rd_idx), .rd_data(rd_data), .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
      .ls_busy(ls_busy), .ls_req_valid(ls_req_valid), .ls_req_write(ls_req_write),
      .ls_req_vreg(ls_req_vreg), .ls_req_addr(ls_req_addr), .ls_req_length(ls_req_length));

endmodule

// File: testbench/exe_ref_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model for the execution unit testbench
// included inside the testbench module, exe_pkg must be imported there
// programs keep each MOV_IMM in opcode0 with its data word in opcode1
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef EXE_REF_MODEL_SVH
`define EXE_REF_MODEL_SVH

typedef struct packed {
   logic      write;
   vreg_idx_t vreg;
   scalar_t   addr;
   vec_len_t  length;
} ls_req_t;

typedef ls_req_t     ls_req_q_t[$];
typedef instr_word_t word_q_t[$];

logic [31:0] lfsr_state = 32'h2390;

// galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
   logic out;
   out = lfsr_state[0];
   lfsr_state = lfsr_state >> 1;
   if (out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
   end
   return out;
endfunction

function automatic logic [31:0] random_bits(int n);
   logic [31:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
   end
   return v;
endfunction

function automatic instr_word_t make_instr(logic [7:0] op, logic [7:0] r1, logic [7:0] r2);
   return {op, r1, r2, 8'h00};
endfunction

// any opcode except MOV_IMM, weighted toward LV
function automatic instr_word_t random_instr();
   logic [7:0] op;
   logic [7:0] r1;
   logic [7:0] r2;
   case (random_bits(3))
      1, 2:    op = LV;
      3:       op = SV;
      4:       op = MTC1;
      5:       op = MFC1;
      6:       op = 8'h5a;   // unknown, runs as NO_OP
      default: op = NO_OP;
   endcase
   r1 = 8'(random_bits(8));
   r2 = 8'(random_bits(8));
   return make_instr(op, r1, r2);
endfunction

function automatic word_q_t random_program(int pairs);
   word_q_t words;
   for (int p = 0; p < pairs; p++) begin
      if (random_bits(2) == 0) begin
         words.push_back(make_instr(MOV_IMM, 8'(random_bits(8)), 8'h00));
         words.push_back(random_bits(32));
      end else begin
         words.push_back(random_instr());
         words.push_back(random_instr());
      end
   end
   return words;
endfunction

// walks the program in order, returns the load/store requests it must produce
function automatic ls_req_q_t expected_requests(word_q_t prog);
   scalar_t   regs [SCALAR_REGS];
   vec_len_t  len;
   ls_req_q_t reqs;
   ls_req_t   r;
   instr_word_t w;
   int i;
   for (int k = 0; k < SCALAR_REGS; k++) begin
      regs[k] = '0;
   end
   len = '0;
   i = 0;
   while (i < prog.size()) begin
      w = prog[i];
      case (w[31:24])
         MOV_IMM: begin
            regs[w[19:16]] = prog[i + 1];
            i++;
         end
         MTC1: len = regs[w[11:8]];
         MFC1: regs[w[19:16]] = len;
         LV, SV: begin
            r.write  = (w[31:24] == SV);
            r.vreg   = w[20:16];
            r.addr   = regs[w[11:8]];
            r.length = len;
            reqs.push_back(r);
         end
         default: ;
      endcase
      i++;
   end
   return reqs;
endfunction

`endif

// File: testbench/vector_exe_unit_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the execution unit front
// the program only grows and expected requests cover it from reset on
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vector_exe_unit_tb import exe_pkg::*; ();

   logic        clk = 1'b0;
   logic        reset;
   logic        opcode_vld;
   instr_word_t opcode0;
   instr_word_t opcode1;
   logic        ls_busy;
   logic        inst_buff_full;
   logic        ls_req_valid;
   logic        ls_req_write;
   vreg_idx_t   ls_req_vreg;
   scalar_t     ls_req_addr;
   vec_len_t    ls_req_length;

   `include "exe_ref_model.svh"

   word_q_t   program_q;
   ls_req_q_t expected_q;
   int accepted = 0;
   int errors = 0;
   int words_pushed = 0;
   int tests_passed = 0;
   int tests_failed = 0;
   logic busy_random = 1'b0;

   vector_exe_unit vector_exe_unit_inst (.*);

   initial begin
      forever #4 clk = ~clk;
   end

   function automatic void check_field(string name, logic [31:0] expected, logic [31:0] actual);
      assert (actual === expected) else begin
         $display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
         errors++;
      end
   endfunction

   // all fields of the request on the ls_req outputs
   function automatic void check_request(ls_req_t exp);
      check_field("ls_req_write", 32'(exp.write), 32'(ls_req_write));
      check_field("ls_req_vreg", 32'(exp.vreg), 32'(ls_req_vreg));
      check_field("ls_req_addr", exp.addr, ls_req_addr);
      check_field("ls_req_length", exp.length, ls_req_length);
   endfunction

   // one falling edge with ls_busy from the LFSR when asked to
   task automatic next_cycle();
      @(negedge clk);
      if (busy_random) begin
         ls_busy = lfsr_bit();
      end
   endtask

   task automatic push_pair(instr_word_t w0, instr_word_t w1);
      while (inst_buff_full) begin
         next_cycle();
      end
      opcode0 = w0;
      opcode1 = w1;
      opcode_vld = 1'b1;
      words_pushed += 2;
      next_cycle();
      opcode_vld = 1'b0;
   endtask

   task automatic add_program(word_q_t words);
      foreach (words[i]) begin
         program_q.push_back(words[i]);
      end
      expected_q = expected_requests(program_q);
   endtask

   task automatic run_program(word_q_t words);
      add_program(words);
      for (int p = 0; p < words.size() / 2; p++) begin
         push_pair(words[2 * p], words[2 * p + 1]);
      end
   endtask

   // settle cycles catch a request that comes twice
   task automatic wait_for_requests();
      while (accepted < expected_q.size()) begin
         next_cycle();
      end
      repeat (20) next_cycle();
      assert (accepted == expected_q.size()) else begin
         $display("request count mismatch: %0d accepted, %0d expected",
            accepted, expected_q.size());
         errors++;
      end
   endtask

   task automatic finish_test(string name, int start);
      if (errors == start) begin
         tests_passed++;
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - start);
      end
   endtask

   // accepted requests against the reference in program order
   always @(posedge clk) begin
      if (reset && ls_req_valid && !ls_busy) begin
         if (accepted < expected_q.size()) begin
            check_request(expected_q[accepted]);
         end else begin
            $display("unexpected load/store request beyond the %0d expected",
               expected_q.size());
            errors++;
         end
         accepted++;
      end
   end

   initial begin
      int cycles;
      cycles = 0;
      while (cycles <= 200 * words_pushed + 1000) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run stalled after %0d cycles with %0d words pushed",
         cycles, words_pushed);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      word_q_t words;
      int start;
      int next;
      reset = 1'b0;
      opcode_vld = 1'b0;
      opcode0 = '0;
      opcode1 = '0;
      ls_busy = 1'b0;

      start = errors;
      next_cycle();
      check_field("ls_req_valid", 32'(0), 32'(ls_req_valid));
      check_field("inst_buff_full", 32'(0), 32'(inst_buff_full));
      next_cycle();
      reset = 1'b1;
      next_cycle();
      check_field("ls_req_valid", 32'(0), 32'(ls_req_valid));
      check_field("inst_buff_full", 32'(0), 32'(inst_buff_full));
      finish_test("reset state", start);

      start = errors;
      words = {make_instr(MOV_IMM, 8'd3, 8'd0), 32'h1000_0040,
               make_instr(LV, 8'd7, 8'd3), make_instr(NO_OP, 8'd0, 8'd0)};
      run_program(words);
      wait_for_requests();
      finish_test("mov_imm then lv", start);

      start = errors;
      words = {make_instr(MOV_IMM, 8'd5, 8'd0), 32'd24,
               make_instr(MTC1, 8'd0, 8'd5), make_instr(LV, 8'd2, 8'd3),
               make_instr(SV, 8'd9, 8'd3), make_instr(NO_OP, 8'd0, 8'd0)};
      run_program(words);
      wait_for_requests();
      finish_test("mtc1 sets length", start);

      start = errors;
      words = {make_instr(MFC1, 8'd8, 8'd0), make_instr(SV, 8'd4, 8'd8)};
      run_program(words);
      wait_for_requests();
      finish_test("mfc1 then sv", start);

      start = errors;
      ls_busy = 1'b1;
      words = {};
      for (int i = 0; i < 12; i++) begin
         words.push_back(make_instr(LV, 8'(i), 8'd3));
         words.push_back(make_instr(SV, 8'(i + 12), 8'd5));
      end
      add_program(words);
      next = 0;
      while (next < 12 && !inst_buff_full) begin
         push_pair(words[2 * next], words[2 * next + 1]);
         next++;
      end
      assert (inst_buff_full) else begin
         $display("inst_buff_full did not rise while ls_busy was held");
         errors++;
      end
      // the stalled request is the next one in program order
      check_request(expected_q[accepted]);
      repeat (16) next_cycle();
      assert (ls_req_valid) else begin
         $display("no load/store request pending during back-pressure");
         errors++;
      end
      check_request(expected_q[accepted]);
      ls_busy = 1'b0;
      while (next < 12) begin
         push_pair(words[2 * next], words[2 * next + 1]);
         next++;
      end
      wait_for_requests();
      finish_test("back-pressure", start);

      start = errors;
      words = random_program(40);
      busy_random = 1'b1;
      run_program(words);
      wait_for_requests();
      busy_random = 1'b0;
      ls_busy = 1'b0;
      finish_test("random programs", start);

      $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: vector_exe_unit.f
+incdir+testbench
verilog/exe_pkg.sv
verilog/exe_issue_if.sv
verilog/opcode_fifo.sv
verilog/instr_decode.sv
verilog/scalar_regfile.sv
verilog/exe_control.sv
verilog/vector_exe_unit.sv
testbench/vector_exe_unit_tb.sv

// File: Makefile
# Verilator simulation of the execution unit front
TOP := vector_exe_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vector_exe_unit.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
